//--- sources.f
+incdir+.
ring_dma_pkg.sv
bram_simple2port.sv
pdu_writer.sv
ring_buffer.sv
dma_reader.sv
pdu_dma_top.sv
pdu_dma_checker.sv
pdu_dma_monitor.sv
tb_pdu_dma.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module tb_pdu_dma -f sources.f -o sim_pdu_dma

./obj_dir/sim_pdu_dma | tee sim.log

if grep -q "^Test passed$" sim.log; then
    exit 0
else
    exit 1
fi

//--- tb_pdu_dma.sv
`timescale 1ns/1ps
`default_nettype none

`include "ring_dma_settings.svh"

module tb_pdu_dma;
    import ring_dma_pkg::*;

    localparam int DRAIN_LIMIT = 5000;
    localparam int MAXLEN      = `MAX_PKT_FLITS;

    logic        clk;
    logic        rst;
    logic        in_valid;
    flit_t       in_flit;
    logic        almost_full;
    logic [15:0] drop_count;
    logic        out_valid;
    flit_t       out_flit;

    int          value_errors;
    int          other_errors;
    int          delivered;
    int          sent;
    int unsigned seed;

    pdu_dma_top UUT (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_flit     (in_flit),
        .almost_full (almost_full),
        .drop_count  (drop_count),
        .out_valid   (out_valid),
        .out_flit    (out_flit)
    );

    pdu_dma_monitor u_monitor (
        .clk          (clk),
        .rst          (rst),
        .out_valid    (out_valid),
        .out_flit     (out_flit),
        .drop_count   (drop_count),
        .value_errors (value_errors),
        .other_errors (other_errors),
        .delivered    (delivered),
        .sent         (sent)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // expected flit of a packet with eop only on the last one
    function automatic flit_t ref_flit(input logic [`FLIT_DW-1:0] word, input int idx,
                                       input int len);
        flit_t f;
        f.data = word;
        f.eop  = (idx == len - 1);
        return f;
    endfunction

    task automatic report_counts();
        $display("%0d value errors, %0d other errors, %0d delivered, %0d dropped, %0d sent",
                 value_errors, other_errors, delivered, drop_count, sent);
    endtask

    // starts on a falling edge and leaves the bus idle for gap cycles
    task automatic send_packet(input int len, input int gap);
        logic [`FLIT_DW-1:0] word;
        for (int i = 0; i < len; i++) begin
            word = $urandom;
            // almost_full holds until the rising edge that takes this flit
            u_monitor.push_flit(ref_flit(word, i, len), almost_full);
            in_valid     = 1'b1;
            in_flit.data = word;
            in_flit.eop  = (i == len - 1);
            @(negedge clk);
        end
        in_valid = 1'b0;
        in_flit  = '0;
        repeat (gap) @(negedge clk);
    endtask

    task automatic run_traffic(input int n, input int min_len, input int max_len,
                               input int min_gap, input int max_gap, input bit extremes);
        int len;
        int gap;
        for (int p = 0; p < n; p++) begin
            if (extremes) begin
                len = ($urandom_range(1, 0) == 1) ? MAXLEN : 1;
            end else begin
                len = $urandom_range(max_len, min_len);
            end
            gap = $urandom_range(max_gap, min_gap);
            send_packet(len, gap);
        end
    endtask

    // done once out_valid has stayed low for quiet_cycles in a row
    task automatic wait_drained(input int quiet_cycles);
        int idle;
        int cycles;
        idle   = 0;
        cycles = 0;
        while (idle < quiet_cycles) begin
            @(negedge clk);
            idle = out_valid ? 0 : idle + 1;
            cycles++;
            if (cycles > DRAIN_LIMIT) begin
                $display("timeout: output did not go quiet within %0d cycles", DRAIN_LIMIT);
                report_counts();
                $display("Test failed");
                $finish;
            end
        end
    endtask

    initial begin
        rst      = 1'b1;
        in_valid = 1'b0;
        in_flit  = '0;
        seed     = $urandom(32'h29b2);
        repeat (8) @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk);

        // sparse traffic that never brings the ring near full
        run_traffic(20, 1, MAXLEN, 20, 40, 1'b0);
        wait_drained(100);
        u_monitor.check_no_drops();

        // long packets push the tail past the wrap limit again and again
        run_traffic(24, MAXLEN - 3, MAXLEN, 3, 8, 1'b0);
        // dense burst at the smallest legal gap
        run_traffic(80, MAXLEN - 2, MAXLEN, 2, 2, 1'b0);
        // single flits mixed with full size packets
        run_traffic(40, 1, MAXLEN, 2, 5, 1'b1);

        wait_drained(100);
        u_monitor.final_check();
        u_monitor.start_quiet();
        repeat (50) @(negedge clk);

        report_counts();
        if (value_errors + other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- pdu_dma_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module pdu_dma_monitor (
    input  logic                clk,
    input  logic                rst,
    input  logic                out_valid,
    input  ring_dma_pkg::flit_t out_flit,
    input  logic [15:0]         drop_count,
    output int                  value_errors,
    output int                  other_errors,
    output int                  delivered,
    output int                  sent
);
    import ring_dma_pkg::*;

    // expected flits of every sent packet in send order
    flit_t exp_flits[$];
    int    exp_len[$];
    // almost_full as the first flit of each sent packet saw it
    logic  exp_full[$];
    // flits of the output packet being collected
    flit_t got[$];
    int    cur_len;
    logic  start_full;
    int    unmatched;
    logic  quiet;

    initial begin
        value_errors = 0;
        other_errors = 0;
        delivered    = 0;
        unmatched    = 0;
        sent         = 0;
        cur_len      = 0;
        start_full   = 1'b0;
        quiet        = 1'b0;
    end

    task automatic push_flit(input flit_t f, input logic full);
        if (cur_len == 0) begin
            start_full = full;
        end
        exp_flits.push_back(f);
        cur_len++;
        if (f.eop) begin
            exp_len.push_back(cur_len);
            exp_full.push_back(start_full);
            cur_len = 0;
            sent++;
        end
    endtask

    task automatic drop_front();
        int   len;
        logic full;
        len  = exp_len.pop_front();
        full = exp_full.pop_front();
        for (int i = 0; i < len; i++) begin
            void'(exp_flits.pop_front());
        end
        if (!full) begin
            $display("packet sent while almost_full was low never came out");
            other_errors++;
        end
        unmatched++;
    endtask

    // packets ahead of the one whose first word matches were dropped at the input
    task automatic match_packet();
        int    len;
        logic  full;
        flit_t e;
        while (exp_len.size() > 0 && exp_flits[0].data != got[0].data) begin
            drop_front();
        end
        if (exp_len.size() == 0) begin
            $display("extra output packet of %0d flits matches no sent packet", got.size());
            other_errors++;
        end else begin
            len  = exp_len.pop_front();
            full = exp_full.pop_front();
            if (full) begin
                $display("packet sent while almost_full was high came out");
                other_errors++;
            end
            if (len != got.size()) begin
                $display("output packet has %0d flits but %0d were sent", got.size(), len);
                other_errors++;
            end
            for (int i = 0; i < len; i++) begin
                e = exp_flits.pop_front();
                if (i < got.size() && got[i] !== e) begin
                    $display("[ERROR] out_flit expected %h got %h", e, got[i]);
                    value_errors++;
                end
            end
            delivered++;
        end
        got.delete();
    endtask

    always @(posedge clk) begin
        if (!rst && out_valid) begin
            if (quiet) begin
                $display("out_valid went high after the pipeline had drained");
                other_errors++;
            end
            got.push_back(out_flit);
            if (out_flit.eop) begin
                match_packet();
            end
        end
    end

    task automatic check_no_drops();
        if (drop_count != 16'd0) begin
            $display("[ERROR] drop_count expected %h got %h", 16'd0, drop_count);
            value_errors++;
        end
    endtask

    // packets still queued never came out and must have been dropped
    task automatic final_check();
        while (exp_len.size() > 0) begin
            drop_front();
        end
        if (got.size() != 0) begin
            $display("output stream stopped inside a packet after %0d flits", got.size());
            other_errors++;
        end
        if (unmatched != int'(drop_count)) begin
            $display("[ERROR] drop_count expected %h got %h", 16'(unmatched), drop_count);
            value_errors++;
        end
        if (delivered + int'(drop_count) != sent) begin
            $display("delivered %0d plus dropped %0d does not add up to %0d sent",
                     delivered, drop_count, sent);
            other_errors++;
        end
    endtask

    task automatic start_quiet();
        quiet = 1'b1;
    endtask

endmodule

`default_nettype wire

//--- pdu_dma_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pdu_dma_checker (
    input logic                clk,
    input logic                rst,
    input logic                in_valid,
    input ring_dma_pkg::flit_t in_flit,
    input logic                almost_full,
    input logic                out_valid,
    input logic                dma_start,
    input logic                dma_done
);

    // a command is open from dma_start until its dma_done
    logic cmd_open;

    always @(posedge clk) begin
        if (rst) begin
            cmd_open <= 1'b0;
        end else if (dma_start) begin
            cmd_open <= 1'b1;
        end else if (dma_done) begin
            cmd_open <= 1'b0;
        end
    end

    a_out_low_in_reset: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high while in reset");

    a_one_cmd_at_a_time: assert property (@(posedge clk) disable iff (rst)
        dma_start |-> !cmd_open)
        else $error("dma_start again before dma_done");

    // two idle cycles at least after each eop
    a_packet_gap: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> !($past(in_valid && in_flit.eop) || $past(in_valid && in_flit.eop, 2)))
        else $error("input packet started less than two cycles after eop");

    a_no_full_after_reset: assert property (@(posedge clk)
        ($past(rst) && !rst) |-> !almost_full)
        else $error("almost_full high right after reset");

endmodule

bind pdu_dma_top pdu_dma_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_flit     (in_flit),
    .almost_full (almost_full),
    .out_valid   (out_valid),
    .dma_start   (dma_start),
    .dma_done    (dma_done)
);

`default_nettype wire

//--- pdu_dma_top.sv
`timescale 1ns/1ps
`default_nettype none

module pdu_dma_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  ring_dma_pkg::flit_t in_flit,
    output logic                almost_full,
    output logic [15:0]         drop_count,
    output logic                out_valid,
    output ring_dma_pkg::flit_t out_flit
);
    import ring_dma_pkg::*;

    // writer to ring
    rb_wr_t   wr;
    logic     update_valid;
    rb_addr_t update_size;
    rb_addr_t wr_base_addr;
    logic     wr_base_addr_valid;

    // ring to reader
    logic     dma_start;
    dma_cmd_t dma_cmd;
    logic     dma_done;
    logic     rd_en;
    rb_addr_t rd_addr;
    logic     rd_valid;
    flit_t    rd_flit;

    pdu_writer u_writer (
        .clk                (clk),
        .rst                (rst),
        .in_valid           (in_valid),
        .in_flit            (in_flit),
        .almost_full        (almost_full),
        .wr_base_addr       (wr_base_addr),
        .wr_base_addr_valid (wr_base_addr_valid),
        .wr                 (wr),
        .update_valid       (update_valid),
        .update_size        (update_size),
        .drop_count         (drop_count)
    );

    ring_buffer u_ring (
        .clk                (clk),
        .rst                (rst),
        .wr                 (wr),
        .update_valid       (update_valid),
        .update_size        (update_size),
        .wr_base_addr       (wr_base_addr),
        .wr_base_addr_valid (wr_base_addr_valid),
        .almost_full        (almost_full),
        .rd_en              (rd_en),
        .rd_addr            (rd_addr),
        .rd_valid           (rd_valid),
        .rd_flit            (rd_flit),
        .dma_start          (dma_start),
        .dma_cmd            (dma_cmd),
        .dma_done           (dma_done)
    );

    dma_reader u_reader (
        .clk       (clk),
        .rst       (rst),
        .dma_start (dma_start),
        .dma_cmd   (dma_cmd),
        .dma_done  (dma_done),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_valid  (rd_valid),
        .rd_flit   (rd_flit),
        .out_valid (out_valid),
        .out_flit  (out_flit)
    );

endmodule

`default_nettype wire

//--- dma_reader.sv
`timescale 1ns/1ps
`default_nettype none

module dma_reader (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   dma_start,
    input  ring_dma_pkg::dma_cmd_t dma_cmd,
    output logic                   dma_done,
    output logic                   rd_en,
    output ring_dma_pkg::rb_addr_t rd_addr,
    input  logic                   rd_valid,
    input  ring_dma_pkg::flit_t    rd_flit,
    output logic                   out_valid,
    output ring_dma_pkg::flit_t    out_flit
);
    import ring_dma_pkg::*;

    // reads still to issue after the current one
    rb_addr_t rd_left;
    // flits still to come back from the RAM
    rb_addr_t ret_left;
    logic     last_ret;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_en    <= 1'b0;
            ret_left <= '0;
            last_ret <= 1'b0;
            dma_done <= 1'b0;
        end else begin
            if (dma_start) begin
                rd_en   <= 1'b1;
                rd_addr <= dma_cmd.base;
                rd_left <= dma_cmd.size - rb_addr_t'(1);
            end else if (rd_en) begin
                if (rd_left == '0) begin
                    rd_en <= 1'b0;
                end else begin
                    rd_addr <= rd_addr + rb_addr_t'(1);
                    rd_left <= rd_left - rb_addr_t'(1);
                end
            end

            if (dma_start) begin
                ret_left <= dma_cmd.size;
            end else if (rd_valid) begin
                ret_left <= ret_left - rb_addr_t'(1);
            end

            // done trails the last output flit by one cycle
            last_ret <= rd_valid && (ret_left == rb_addr_t'(1));
            dma_done <= last_ret;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= rd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid) begin
            out_flit <= rd_flit;
        end
    end

endmodule

`default_nettype wire

//--- ring_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ring_dma_settings.svh"

module ring_buffer (
    input  logic                   clk,
    input  logic                   rst,
    input  ring_dma_pkg::rb_wr_t   wr,
    input  logic                   update_valid,
    input  ring_dma_pkg::rb_addr_t update_size,
    output ring_dma_pkg::rb_addr_t wr_base_addr,
    output logic                   wr_base_addr_valid,
    output logic                   almost_full,
    input  logic                   rd_en,
    input  ring_dma_pkg::rb_addr_t rd_addr,
    output logic                   rd_valid,
    output ring_dma_pkg::flit_t    rd_flit,
    output logic                   dma_start,
    output ring_dma_pkg::dma_cmd_t dma_cmd,
    input  logic                   dma_done
);
    import ring_dma_pkg::*;

    localparam int DEPTH     = `RB_DEPTH;
    localparam int THRESHOLD = `RB_THRESHOLD;
    localparam int MAX_SLOT  = DEPTH - THRESHOLD;

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        DELAY
    } state_t;

    state_t               state;
    rb_addr_t             head;
    rb_addr_t             tail;
    rb_addr_t             last_tail;
    rb_addr_t             occupied_slot;
    rb_addr_t             send_slot;
    rb_addr_t             free_slot;
    logic                 wrap;
    logic                 bram_delay;
    logic [RB_AWIDTH:0]   tail_sum;
    logic                 rd_en_r;
    rb_addr_t             rd_addr_r1;
    rb_addr_t             rd_addr_r2;

    assign wr_base_addr = tail;
    assign wrap         = tail < head;
    assign tail_sum     = {1'b0, tail} + {1'b0, update_size};

    // one slot always stays empty so full and empty differ
    assign occupied_slot = wrap ? (last_tail - head + tail) : (tail - head);
    assign send_slot     = wrap ? (last_tail - head) : (tail - head);

    // room a new packet can still use, counting the jump back to slot zero
    always_comb begin
        if (wrap) begin
            free_slot = head - tail - rb_addr_t'(1);
        end else if (tail >= rb_addr_t'(MAX_SLOT - THRESHOLD)) begin
            free_slot = (head == '0) ? '0 : head - rb_addr_t'(1);
        end else begin
            free_slot = rb_addr_t'(DEPTH - 1) - occupied_slot;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tail               <= '0;
            last_tail          <= '0;
            wr_base_addr_valid <= 1'b0;
            almost_full        <= 1'b0;
        end else begin
            if (update_valid) begin
                if (tail_sum < MAX_SLOT) begin
                    tail <= tail_sum[RB_AWIDTH-1:0];
                end else begin
                    tail      <= '0;
                    last_tail <= tail_sum[RB_AWIDTH-1:0];
                end
            end
            wr_base_addr_valid <= update_valid;
            almost_full        <= free_slot < rb_addr_t'(2 * THRESHOLD);
        end
    end

    // head moves past each packet as its eop comes back
    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
        end else if (rd_valid && rd_flit.eop) begin
            if (rd_addr_r2 + rb_addr_t'(1) >= rb_addr_t'(MAX_SLOT)) begin
                head <= '0;
            end else begin
                head <= rd_addr_r2 + rb_addr_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            dma_start  <= 1'b0;
            bram_delay <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (occupied_slot > '0) begin
                        dma_start    <= 1'b1;
                        dma_cmd.base <= head;
                        dma_cmd.size <= send_slot;
                        state        <= WAIT;
                    end
                end
                WAIT: begin
                    dma_start <= 1'b0;
                    if (dma_done) begin
                        state <= DELAY;
                    end
                end
                DELAY: begin
                    // give the RAM two cycles before the next command
                    bram_delay <= !bram_delay;
                    if (bram_delay) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // strobe and address follow the two-cycle RAM read
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_en_r  <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            rd_en_r  <= rd_en;
            rd_valid <= rd_en_r;
        end
    end

    always_ff @(posedge clk) begin
        rd_addr_r1 <= rd_addr;
        rd_addr_r2 <= rd_addr_r1;
    end

    bram_simple2port pdu_buffer (
        .clk     (clk),
        .wr      (wr),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .q       (rd_flit)
    );

endmodule

`default_nettype wire

//--- pdu_writer.sv
`timescale 1ns/1ps
`default_nettype none

module pdu_writer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  ring_dma_pkg::flit_t    in_flit,
    input  logic                   almost_full,
    input  ring_dma_pkg::rb_addr_t wr_base_addr,
    input  logic                   wr_base_addr_valid,
    output ring_dma_pkg::rb_wr_t   wr,
    output logic                   update_valid,
    output ring_dma_pkg::rb_addr_t update_size,
    output logic [15:0]            drop_count
);
    import ring_dma_pkg::*;

    logic     in_pkt;
    logic     dropping;
    logic     first;
    logic     keep;
    rb_addr_t offset;
    rb_addr_t base_addr;
    rb_addr_t cur_base;
    rb_addr_t pkt_len;

    // accept or drop is decided once, on the first flit
    assign first = in_valid && !in_pkt;
    assign keep  = first ? !almost_full : !dropping;

    // new tail is already on wr_base_addr in its confirmation cycle
    assign cur_base = wr_base_addr_valid ? wr_base_addr : base_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_pkt       <= 1'b0;
            dropping     <= 1'b0;
            offset       <= '0;
            base_addr    <= '0;
            wr.en        <= 1'b0;
            update_valid <= 1'b0;
            drop_count   <= '0;
        end else begin
            wr.en        <= 1'b0;
            // one cycle after the eop flit lands in the RAM
            update_valid <= wr.en && wr.flit.eop;
            if (wr_base_addr_valid) begin
                base_addr <= wr_base_addr;
            end
            if (in_valid) begin
                if (first) begin
                    dropping <= almost_full;
                end
                if (keep) begin
                    wr.en   <= 1'b1;
                    wr.addr <= cur_base + offset;
                    wr.flit <= in_flit;
                end
                if (in_flit.eop) begin
                    in_pkt <= 1'b0;
                    offset <= '0;
                    if (!keep) begin
                        drop_count <= drop_count + 16'd1;
                    end
                end else begin
                    in_pkt <= 1'b1;
                    offset <= offset + rb_addr_t'(1);
                end
            end
        end
    end

    // packet length, handed over together with update_valid
    always_ff @(posedge clk) begin
        if (in_valid && in_flit.eop) begin
            pkt_len <= offset + rb_addr_t'(1);
        end
        update_size <= pkt_len;
    end

endmodule

`default_nettype wire

//--- bram_simple2port.sv
`timescale 1ns/1ps
`default_nettype none

`include "ring_dma_settings.svh"

module bram_simple2port (
    input  logic                   clk,
    input  ring_dma_pkg::rb_wr_t   wr,
    input  logic                   rd_en,
    input  ring_dma_pkg::rb_addr_t rd_addr,
    output ring_dma_pkg::flit_t    q
);
    import ring_dma_pkg::*;

    flit_t mem [`RB_DEPTH];
    flit_t rd_q;

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.flit;
        end
    end

    // first stage is the array read, second the output register
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_q <= mem[rd_addr];
        end
        q <= rd_q;
    end

endmodule

`default_nettype wire

//--- ring_dma_pkg.sv
`default_nettype none

package ring_dma_pkg;

`include "ring_dma_settings.svh"

    localparam int RB_AWIDTH = $clog2(`RB_DEPTH);

    // slot address, also used for sizes in flits
    typedef logic [RB_AWIDTH-1:0] rb_addr_t;

    // one flit as stored in the ring and carried on both streams
    typedef struct packed {
        logic [`FLIT_DW-1:0] data;
        logic                eop;
    } flit_t;

    // block RAM write port
    typedef struct packed {
        logic     en;
        rb_addr_t addr;
        flit_t    flit;
    } rb_wr_t;

    // one bulk transfer
    typedef struct packed {
        rb_addr_t base;
        rb_addr_t size;
    } dma_cmd_t;

endpackage

`default_nettype wire

//--- ring_dma_settings.svh
`ifndef RING_DMA_SETTINGS_SVH
`define RING_DMA_SETTINGS_SVH

// number of flit slots in the ring
`define RB_DEPTH 64

// headroom in flits kept below the top of the ring
// a packet may only start below RB_DEPTH - RB_THRESHOLD
`define RB_THRESHOLD 8

// width of the data word in one flit
`define FLIT_DW 32

// largest packet in flits, not above RB_THRESHOLD
`define MAX_PKT_FLITS 8

`endif
